//--- verilog/breakout_pkg.sv
package breakout_pkg;

	localparam int SCORE_WIDTH     = 24; // Six hex digits on the display
	localparam int POINTS_WIDTH    = 3;  // Largest award is 6
	localparam int DIR_COUNT_WIDTH = 2;  // Counters wrap modulo 4

	typedef enum logic [1:0]
	{
		hit_none       = 2'd0, // Ball missed, no brick
		hit_vertical   = 2'd1,
		hit_horizontal = 2'd2,
		hit_diagonal   = 2'd3
	} hit_kind_t;

	typedef enum logic [2:0]
	{
		col_blue   = 3'b001,
		col_turq   = 3'b011,
		col_green  = 3'b010,
		col_yellow = 3'b110,
		col_pink   = 3'b101,
		col_red    = 3'b100
	} brick_colour_t;

	typedef enum logic [1:0]
	{
		st_idle = 2'd0, // Waiting for a request
		st_busy = 2'd1, // Event handed to execute stage
		st_ack  = 2'd2  // Ack held until req drops
	} decode_state_t;

	// Points awarded per brick colour, zero for the two unused codes
	function automatic logic [POINTS_WIDTH-1:0] colour_points(input brick_colour_t colour);
		case (colour)
			col_blue:   colour_points = 3'd1;
			col_turq:   colour_points = 3'd2;
			col_green:  colour_points = 3'd3;
			col_yellow: colour_points = 3'd4;
			col_pink:   colour_points = 3'd5;
			col_red:    colour_points = 3'd6;
			default:    colour_points = 3'd0; // 000 and 111
		endcase
	endfunction

endpackage

//--- verilog/hit_decode.sv
module hit_decode
	import breakout_pkg::*;
(
	input  logic                    CLOCK_50,
	input  logic                    reset_dividers,
	input  logic                    hit_req,
	input  hit_kind_t               hit_kind,
	input  brick_colour_t           brick_colour,
	input  logic                    applied,
	output logic                    hit_ack,
	output logic                    hit_valid,
	output hit_kind_t               hit_kind_q,
	output logic [POINTS_WIDTH-1:0] points,
	output logic                    colour_valid
);

	decode_state_t           state;
	logic                    take_event; // New event accepted this cycle
	logic [POINTS_WIDTH-1:0] new_points;

	assign take_event = (state == st_idle) && hit_req;
	assign new_points = colour_points(brick_colour);

	// Four-phase handshake sequencing
	always_ff @(posedge CLOCK_50 or negedge reset_dividers)
	begin
		if (!reset_dividers)
		begin
			state     <= st_idle;
			hit_ack   <= 1'b0;
			hit_valid <= 1'b0;
		end
		else
		begin
			hit_valid <= 1'b0; // Single-cycle pulse
			case (state)
				st_idle:
				begin
					if (hit_req)
					begin
						hit_valid <= 1'b1;
						state     <= st_busy;
					end
				end
				st_busy:
				begin
					if (applied) // Execute stage has committed the event
					begin
						hit_ack <= 1'b1;
						state   <= st_ack;
					end
				end
				st_ack:
				begin
					if (!hit_req)
					begin
						hit_ack <= 1'b0;
						state   <= st_idle;
					end
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// Event payload latched once per request
	always_ff @(posedge CLOCK_50 or negedge reset_dividers)
	begin
		if (!reset_dividers)
		begin
			hit_kind_q   <= hit_none;
			points       <= '0;
			colour_valid <= 1'b0;
		end
		else if (take_event)
		begin
			hit_kind_q   <= hit_kind;
			points       <= new_points;
			colour_valid <= (new_points != '0); // Only legal colours score
		end
	end

	// Pulse to execute stage only when leaving idle
	assert property (@(posedge CLOCK_50) disable iff (!reset_dividers)
		hit_valid |-> (state == st_busy) && ($past(state) == st_idle));

	assert property (@(posedge CLOCK_50) disable iff (!reset_dividers)
		(state == st_idle) |-> !hit_ack);

	assert property (@(posedge CLOCK_50) disable iff (!reset_dividers)
		!(hit_ack && hit_valid));

endmodule

//--- verilog/score_execute.sv
module score_execute
	import breakout_pkg::*;
#(
	parameter int BRICK_TOTAL = 60
)
(
	input  logic                                 CLOCK_50,
	input  logic                                 reset_dividers,
	input  logic                                 hit_valid,
	input  hit_kind_t                            hit_kind_q,
	input  logic [POINTS_WIDTH-1:0]              points,
	input  logic                                 colour_valid,
	output logic                                 applied,
	output logic [SCORE_WIDTH-1:0]               score,
	output logic [DIR_COUNT_WIDTH-1:0]           v_col_count,
	output logic [DIR_COUNT_WIDTH-1:0]           h_col_count,
	output logic [DIR_COUNT_WIDTH-1:0]           d_col_count,
	output logic [$clog2(BRICK_TOTAL + 1) - 1:0] bricks_cleared,
	output logic                                 all_bricks_down
);

	localparam int COUNT_WIDTH = $clog2(BRICK_TOTAL + 1);

	logic                   accept;     // Event changes state
	logic [COUNT_WIDTH-1:0] next_count;

	assign accept     = hit_valid && !all_bricks_down; // Frozen once game is over
	assign next_count = bricks_cleared + 1'b1;

	always_ff @(posedge CLOCK_50 or negedge reset_dividers)
	begin
		if (!reset_dividers)
		begin
			applied         <= 1'b0;
			score           <= '0;
			v_col_count     <= '0;
			h_col_count     <= '0;
			d_col_count     <= '0;
			bricks_cleared  <= '0;
			all_bricks_down <= 1'b0;
		end
		else
		begin
			applied <= hit_valid; // Acknowledge even after game end
			if (accept)
			begin
				if (hit_kind_q == hit_none)
				begin
					// Miss resets direction history
					v_col_count <= '0;
					h_col_count <= '0;
					d_col_count <= '0;
				end
				else
				begin
					case (hit_kind_q)
						hit_vertical:   v_col_count <= v_col_count + 1'b1;
						hit_horizontal: h_col_count <= h_col_count + 1'b1;
						hit_diagonal:   d_col_count <= d_col_count + 1'b1;
						default:        ;
					endcase

					bricks_cleared <= next_count; // Invalid colours still count
					if (next_count == COUNT_WIDTH'(BRICK_TOTAL))
						all_bricks_down <= 1'b1;

					if (colour_valid)
						score <= score + SCORE_WIDTH'(points);
					else
						score <= '0; // Bad colour wipes the score
				end
			end
		end
	end

	// Score only moves in response to an event
	assert property (@(posedge CLOCK_50) disable iff (!reset_dividers)
		!hit_valid |=> $stable(score));

	assert property (@(posedge CLOCK_50) disable iff (!reset_dividers)
		bricks_cleared <= COUNT_WIDTH'(BRICK_TOTAL));

endmodule

//--- verilog/score_display.sv
module score_display
	import breakout_pkg::*;
(
	input  logic [SCORE_WIDTH-1:0] score,
	output logic [6:0]             HEX0,
	output logic [6:0]             HEX1,
	output logic [6:0]             HEX2,
	output logic [6:0]             HEX3,
	output logic [6:0]             HEX4,
	output logic [6:0]             HEX5
);

	logic [6:0] seg [6]; // One pattern per digit, index 0 is least significant

	// Active-low hex font, bit 0 is segment a, bit 6 is segment g
	function automatic logic [6:0] hex_font(input logic [3:0] nibble);
		case (nibble)
			4'h0: hex_font = 7'h40;
			4'h1: hex_font = 7'h79;
			4'h2: hex_font = 7'h24;
			4'h3: hex_font = 7'h30;
			4'h4: hex_font = 7'h19;
			4'h5: hex_font = 7'h12;
			4'h6: hex_font = 7'h02;
			4'h7: hex_font = 7'h78;
			4'h8: hex_font = 7'h00;
			4'h9: hex_font = 7'h10;
			4'hA: hex_font = 7'h08;
			4'hB: hex_font = 7'h03; // Lower case b
			4'hC: hex_font = 7'h46;
			4'hD: hex_font = 7'h21; // Lower case d
			4'hE: hex_font = 7'h06;
			default: hex_font = 7'h0E;
		endcase
	endfunction

	always_comb
	begin
		for (int i = 0; i < 6; i++)
			seg[i] = hex_font(score[4*i +: 4]);
	end

	assign HEX0 = seg[0];
	assign HEX1 = seg[1];
	assign HEX2 = seg[2];
	assign HEX3 = seg[3];
	assign HEX4 = seg[4];
	assign HEX5 = seg[5];

endmodule

//--- verilog/breakout_score_top.sv
module breakout_score_top
	import breakout_pkg::*;
#(
	parameter int BRICK_TOTAL = 60
)
(
	input  logic                                 CLOCK_50,
	input  logic                                 reset_dividers, // Async, active low
	input  logic                                 hit_req,
	input  hit_kind_t                            hit_kind,
	input  brick_colour_t                        brick_colour,
	output logic                                 hit_ack,
	output logic [6:0]                           HEX0,
	output logic [6:0]                           HEX1,
	output logic [6:0]                           HEX2,
	output logic [6:0]                           HEX3,
	output logic [6:0]                           HEX4,
	output logic [6:0]                           HEX5,
	output logic [DIR_COUNT_WIDTH-1:0]           v_col_count,
	output logic [DIR_COUNT_WIDTH-1:0]           h_col_count,
	output logic [DIR_COUNT_WIDTH-1:0]           d_col_count,
	output logic [$clog2(BRICK_TOTAL + 1) - 1:0] bricks_cleared,
	output logic                                 all_bricks_down
);

	logic                    hit_valid;    // Decode to execute pulse
	hit_kind_t               hit_kind_q;
	logic [POINTS_WIDTH-1:0] points;
	logic                    colour_valid;
	logic                    applied;      // Execute to decode pulse
	logic [SCORE_WIDTH-1:0]  score;

	hit_decode u_hit_decode (
		.CLOCK_50       (CLOCK_50),
		.reset_dividers (reset_dividers),
		.hit_req        (hit_req),
		.hit_kind       (hit_kind),
		.brick_colour   (brick_colour),
		.applied        (applied),
		.hit_ack        (hit_ack),
		.hit_valid      (hit_valid),
		.hit_kind_q     (hit_kind_q),
		.points         (points),
		.colour_valid   (colour_valid)
	);

	score_execute #(
		.BRICK_TOTAL (BRICK_TOTAL)
	) u_score_execute (
		.CLOCK_50        (CLOCK_50),
		.reset_dividers  (reset_dividers),
		.hit_valid       (hit_valid),
		.hit_kind_q      (hit_kind_q),
		.points          (points),
		.colour_valid    (colour_valid),
		.applied         (applied),
		.score           (score),
		.v_col_count     (v_col_count),
		.h_col_count     (h_col_count),
		.d_col_count     (d_col_count),
		.bricks_cleared  (bricks_cleared),
		.all_bricks_down (all_bricks_down)
	);

	score_display u_score_display (
		.score (score),
		.HEX0  (HEX0),
		.HEX1  (HEX1),
		.HEX2  (HEX2),
		.HEX3  (HEX3),
		.HEX4  (HEX4),
		.HEX5  (HEX5)
	);

endmodule

//--- dv/breakout_score_tb.sv
module breakout_score_tb
	import breakout_pkg::*;
;

	localparam int BRICK_TOTAL = 12;
	localparam int COUNT_WIDTH = $clog2(BRICK_TOTAL + 1);

	typedef struct packed
	{
		logic [1:0]             kind;
		logic [2:0]             colour;
		logic [SCORE_WIDTH-1:0] score;
		logic [1:0]             v_count;
		logic [1:0]             h_count;
		logic [1:0]             d_count;
		logic [COUNT_WIDTH-1:0] bricks;
		logic                   done;
	} golden_row_t;

	logic                       CLOCK_50;
	logic                       reset_dividers;
	logic                       hit_req;
	hit_kind_t                  hit_kind;
	brick_colour_t              brick_colour;
	logic                       hit_ack;
	logic [6:0]                 HEX0;
	logic [6:0]                 HEX1;
	logic [6:0]                 HEX2;
	logic [6:0]                 HEX3;
	logic [6:0]                 HEX4;
	logic [6:0]                 HEX5;
	logic [DIR_COUNT_WIDTH-1:0] v_col_count;
	logic [DIR_COUNT_WIDTH-1:0] h_col_count;
	logic [DIR_COUNT_WIDTH-1:0] d_col_count;
	logic [COUNT_WIDTH-1:0]     bricks_cleared;
	logic                       all_bricks_down;

	golden_row_t rows[$];
	int          error_count = 0;
	int          cycle_count = 0;
	int          cycle_limit = 0;

	breakout_score_top #(
		.BRICK_TOTAL (BRICK_TOTAL)
	) u_breakout_score_top (
		.CLOCK_50        (CLOCK_50),
		.reset_dividers  (reset_dividers),
		.hit_req         (hit_req),
		.hit_kind        (hit_kind),
		.brick_colour    (brick_colour),
		.hit_ack         (hit_ack),
		.HEX0            (HEX0),
		.HEX1            (HEX1),
		.HEX2            (HEX2),
		.HEX3            (HEX3),
		.HEX4            (HEX4),
		.HEX5            (HEX5),
		.v_col_count     (v_col_count),
		.h_col_count     (h_col_count),
		.d_col_count     (d_col_count),
		.bricks_cleared  (bricks_cleared),
		.all_bricks_down (all_bricks_down)
	);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever #2 CLOCK_50 = ~CLOCK_50;
	end

	// Run limit, armed once the event count is known
	initial
	begin
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit)
		begin
			@(posedge CLOCK_50);
			cycle_count++;
		end
		$display("Timeout after %0d cycles waiting on the handshake", cycle_count);
		$display("sim failed");
		$fatal(1, "run limit reached");
	end

	// Active-low pattern from the list of lit segments
	function automatic logic [6:0] segments_from(input string lit);
		logic [6:0] pattern;
		pattern = 7'h7F;
		for (int i = 0; i < lit.len(); i++)
			pattern[lit[i] - "a"] = 1'b0;
		return pattern;
	endfunction

	function automatic logic [6:0] digit_segments(input logic [3:0] nibble);
		case (nibble)
			4'h0: return segments_from("abcdef");
			4'h1: return segments_from("bc");
			4'h2: return segments_from("abdeg");
			4'h3: return segments_from("abcdg");
			4'h4: return segments_from("bcfg");
			4'h5: return segments_from("acdfg");
			4'h6: return segments_from("acdefg");
			4'h7: return segments_from("abc");
			4'h8: return segments_from("abcdefg");
			4'h9: return segments_from("abcdfg");
			4'hA: return segments_from("abcefg");
			4'hB: return segments_from("cdefg");
			4'hC: return segments_from("adef");
			4'hD: return segments_from("bcdeg");
			4'hE: return segments_from("adefg");
			default: return segments_from("aefg");
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual === expected)
		else
		begin
			error_count++;
			$display("FAILED %s expected %h got %h", name, expected, actual);
			$display("sim failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic compare_outputs(input golden_row_t row);
		check_value("HEX0", HEX0, digit_segments(row.score[3:0]));
		check_value("HEX1", HEX1, digit_segments(row.score[7:4]));
		check_value("HEX2", HEX2, digit_segments(row.score[11:8]));
		check_value("HEX3", HEX3, digit_segments(row.score[15:12]));
		check_value("HEX4", HEX4, digit_segments(row.score[19:16]));
		check_value("HEX5", HEX5, digit_segments(row.score[23:20]));
		check_value("v_col_count", v_col_count, row.v_count);
		check_value("h_col_count", h_col_count, row.h_count);
		check_value("d_col_count", d_col_count, row.d_count);
		check_value("bricks_cleared", bricks_cleared, row.bricks);
		check_value("all_bricks_down", all_bricks_down, row.done);
	endtask

	task automatic load_golden();
		int          fd;
		int          fields;
		string       line;
		logic [31:0] val [8];
		golden_row_t row;
		fd = $fopen("dv/hits_golden.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the golden file dv/hits_golden.txt");
			$display("sim failed");
			$fatal(1, "missing stimulus");
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line[0] != "/") // Skip comment lines
			begin
				fields = $sscanf(line, "%h %h %h %h %h %h %h %h", val[0], val[1], val[2],
					val[3], val[4], val[5], val[6], val[7]);
				if (fields == 8)
				begin
					row.kind    = val[0][1:0];
					row.colour  = val[1][2:0];
					row.score   = val[2][SCORE_WIDTH-1:0];
					row.v_count = val[3][1:0];
					row.h_count = val[4][1:0];
					row.d_count = val[5][1:0];
					row.bricks  = val[6][COUNT_WIDTH-1:0];
					row.done    = val[7][0];
					rows.push_back(row);
				end
			end
		end
		$fclose(fd);
	endtask

	// One four-phase transfer, with req held two extra cycles after ack
	task automatic run_event(input golden_row_t row);
		assert (!hit_ack)
		else
		begin
			error_count++;
			$display("hit_ack was still high before a new request");
			$display("sim failed");
			$fatal(1, "handshake error");
		end
		hit_kind     = hit_kind_t'(row.kind);
		brick_colour = brick_colour_t'(row.colour);
		hit_req      = 1'b1;
		@(posedge CLOCK_50);
		#1;
		while (!hit_ack)
		begin
			@(posedge CLOCK_50);
			#1;
		end
		compare_outputs(row);
		repeat (2)
		begin
			@(posedge CLOCK_50);
			#1;
			assert (hit_ack)
			else
			begin
				error_count++;
				$display("hit_ack dropped while hit_req was still high");
				$display("sim failed");
				$fatal(1, "handshake error");
			end
			compare_outputs(row); // No second update while req stays high
		end
		hit_req = 1'b0;
		@(posedge CLOCK_50);
		#1;
		while (hit_ack)
		begin
			@(posedge CLOCK_50);
			#1;
		end
		compare_outputs(row);
	endtask

	initial
	begin
		golden_row_t idle_row;
		hit_req        = 1'b0;
		hit_kind       = hit_none;
		brick_colour   = col_blue;
		reset_dividers = 1'b0;
		idle_row       = '0;

		load_golden();
		if (rows.size() == 0)
		begin
			$display("The golden file holds no events");
			$display("sim failed");
			$fatal(1, "empty stimulus");
		end
		cycle_limit = rows.size() * 12 + 10 + 50;

		repeat (10) @(posedge CLOCK_50);
		#1;
		reset_dividers = 1'b1;

		// State straight out of reset
		compare_outputs(idle_row);
		check_value("hit_ack", hit_ack, 1'b0);
		@(posedge CLOCK_50);
		#1;
		compare_outputs(idle_row);

		foreach (rows[i])
			run_event(rows[i]);

		if (error_count == 0)
		begin
			$display("sim passed");
		end
		else
		begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- list.f
verilog/breakout_pkg.sv
verilog/hit_decode.sv
verilog/score_execute.sv
verilog/score_display.sv
verilog/breakout_score_top.sv
dv/breakout_score_tb.sv

//--- dv/hits_golden.txt
// kind colour score v_count h_count d_count bricks_cleared all_bricks_down
// kind 0 miss 1 vertical 2 horizontal 3 diagonal, colour is the 3-bit code, all hex

// Vertical hits on four colours, counter wraps on the fourth
1 1 000001 1 0 0 1 0
1 3 000003 2 0 0 2 0
1 2 000006 3 0 0 3 0
1 6 00000a 0 0 0 4 0

// Pink and red push the score past 0x0F into HEX1
2 5 00000f 0 1 0 5 0
2 4 000015 0 2 0 6 0
3 4 00001b 0 2 1 7 0

// Miss clears the counters only
0 4 00001b 0 0 0 7 0
3 1 00001c 0 0 1 8 0

// Colour codes 000 and 111 wipe the score but still count
2 0 000000 0 1 1 9 0
2 1 000001 0 2 1 a 0
1 7 000000 1 2 1 b 0

// Twelfth brick ends the game
1 6 000004 2 2 1 c 1

// Everything frozen after game end
2 5 000004 2 2 1 c 1
0 1 000004 2 2 1 c 1
3 3 000004 2 2 1 c 1
1 7 000004 2 2 1 c 1
